//--- hdl/spi_seq_config.svh
/*
 * build-time configuration of the SPI sequencer
 * bus address width, memory size, version number
 */
`ifndef SPI_SEQ_CONFIG_SVH
`define SPI_SEQ_CONFIG_SVH

// width of the register bus address
`define SPI_ABUS_WIDTH 16

// bytes in each of the tx and rx memories, power of two and at least 2
// tx window starts at address 8, rx window follows it
`define SPI_MEM_BYTES 16

// value returned by a read of address 0
`define SPI_VERSION 1

`endif

//--- hdl/spi_seq_pkg.sv
/*
 * shared types of the SPI sequencer
 * register offsets, counter type, bus byte type
 */
package spi_seq_pkg;

    // offsets of the control registers below the memory windows
    typedef enum logic [2:0] {
        reg_soft_rst = 3'd0,  // write: soft reset, read: version
        reg_start    = 3'd1,  // write: start, read: done flag
        reg_reserved = 3'd2,
        reg_bits_lo  = 3'd3,
        reg_bits_hi  = 3'd4,
        reg_wait_lo  = 3'd5,
        reg_wait_hi  = 3'd6,
        reg_repeat   = 3'd7   // 0 means endless
    } reg_addr_e;

    // bit count, gap length and bit index
    typedef logic [15:0] bit_cnt_t;

    // register bus data
    typedef logic [7:0] byte_t;

endpackage

//--- hdl/spi_ctrl_if.sv
/*
 * control interface between register block and sequencer
 * frame config and start/soft reset pulses one way, done pulse the other
 */
`timescale 1ns/10ps

interface spi_ctrl_if;
    import spi_seq_pkg::*;

    logic     start;       // one cycle, bus write to address 1
    logic     soft_rst;    // one cycle, bus write to address 0
    bit_cnt_t bit_out;     // bits per frame
    bit_cnt_t wait_len;    // gap cycles after each frame
    byte_t    repeat_len;  // frames per start, 0 is endless
    logic     done;        // one cycle at end of the last gap

    modport regs (
        output start,
        output soft_rst,
        output bit_out,
        output wait_len,
        output repeat_len,
        input  done
    );

    modport seq (
        input  start,
        input  soft_rst,
        input  bit_out,
        input  wait_len,
        input  repeat_len,
        output done
    );

endinterface

//--- hdl/spi_regs.sv
/*
 * register block: config registers, start and soft reset decode,
 * done flag, bus read mux over registers and memory windows
 */
`timescale 1ns/10ps
`include "spi_seq_config.svh"

module spi_regs (
    input  logic                                 SPI_CLK,
    input  logic                                 RST,
    input  logic [`SPI_ABUS_WIDTH-1:0]           bus_add,
    input  spi_seq_pkg::byte_t                   bus_data_in,
    input  logic                                 bus_wr,
    output spi_seq_pkg::byte_t                   bus_data_out,
    output logic                                 mem_we,
    output logic [$clog2(2*`SPI_MEM_BYTES)-1:0]  mem_idx,
    output spi_seq_pkg::byte_t                   mem_wdata,
    input  spi_seq_pkg::byte_t                   mem_rdata,
    spi_ctrl_if.regs                             ctrl
);
    import spi_seq_pkg::*;

    localparam bit_cnt_t def_bit_out = bit_cnt_t'(8 * `SPI_MEM_BYTES);

    bit_cnt_t                    bit_out_q;
    bit_cnt_t                    wait_q;
    byte_t                       repeat_q;
    logic                        done_flag;
    byte_t                       rd_q;       // register read data, one cycle late
    logic [`SPI_ABUS_WIDTH-1:0]  prev_add;
    logic [`SPI_ABUS_WIDTH-1:0]  mem_off;
    logic                        reg_hit;
    logic                        cfg_rst;

    assign reg_hit = (bus_add < `SPI_ABUS_WIDTH'(8));

    // command pulses straight from the bus write
    assign ctrl.soft_rst = bus_wr && (bus_add == `SPI_ABUS_WIDTH'(reg_soft_rst));
    assign ctrl.start    = bus_wr && (bus_add == `SPI_ABUS_WIDTH'(reg_start));
    assign cfg_rst       = RST || ctrl.soft_rst;

    always_ff @(posedge SPI_CLK) begin
        if (cfg_rst) begin
            bit_out_q <= def_bit_out;
            wait_q    <= '0;
            repeat_q  <= 8'd1;
        end else if (bus_wr && reg_hit) begin
            case (reg_addr_e'(bus_add[2:0]))
                reg_bits_lo: bit_out_q[7:0]  <= bus_data_in;
                reg_bits_hi: bit_out_q[15:8] <= bus_data_in;
                reg_wait_lo: wait_q[7:0]     <= bus_data_in;
                reg_wait_hi: wait_q[15:8]    <= bus_data_in;
                reg_repeat:  repeat_q        <= bus_data_in;
                default: ;  // commands and reserved slot hold no data
            endcase
        end
    end

    assign ctrl.bit_out    = bit_out_q;
    assign ctrl.wait_len   = wait_q;
    assign ctrl.repeat_len = repeat_q;

    // done reads 0 from start until the sequencer finishes
    always_ff @(posedge SPI_CLK) begin
        if (cfg_rst)
            done_flag <= 1'b1;
        else if (ctrl.start)
            done_flag <= 1'b0;
        else if (ctrl.done)
            done_flag <= 1'b1;
    end

    always_ff @(posedge SPI_CLK) begin
        prev_add <= bus_add;
        if (reg_hit) begin
            case (reg_addr_e'(bus_add[2:0]))
                reg_soft_rst: rd_q <= byte_t'(`SPI_VERSION);
                reg_start:    rd_q <= {7'd0, done_flag};
                reg_reserved: rd_q <= '0;  // clock divider not implemented
                reg_bits_lo:  rd_q <= bit_out_q[7:0];
                reg_bits_hi:  rd_q <= bit_out_q[15:8];
                reg_wait_lo:  rd_q <= wait_q[7:0];
                reg_wait_hi:  rd_q <= wait_q[15:8];
                reg_repeat:   rd_q <= repeat_q;
            endcase
        end
    end

    // memory byte index counts from the start of the tx window
    assign mem_off   = bus_add - `SPI_ABUS_WIDTH'(8);
    assign mem_idx   = mem_off[$bits(mem_idx)-1:0];
    assign mem_wdata = bus_data_in;
    assign mem_we    = bus_wr && !reg_hit &&
                       (bus_add < `SPI_ABUS_WIDTH'(8 + `SPI_MEM_BYTES));

    always_comb begin
        if (prev_add < `SPI_ABUS_WIDTH'(8))
            bus_data_out = rd_q;
        else if (prev_add < `SPI_ABUS_WIDTH'(8 + 2 * `SPI_MEM_BYTES))
            bus_data_out = mem_rdata;
        else
            bus_data_out = '0;  // outside both windows
    end

endmodule

//--- hdl/spi_shift_mem.sv
/*
 * tx and rx bit memories
 * byte access from the bus, bit access from the sequencer
 */
`timescale 1ns/10ps
`include "spi_seq_config.svh"

module spi_shift_mem (
    input  logic                                 SPI_CLK,
    input  logic                                 byte_we,
    input  logic [$clog2(2*`SPI_MEM_BYTES)-1:0]  byte_idx,
    input  spi_seq_pkg::byte_t                   byte_wdata,
    output spi_seq_pkg::byte_t                   byte_rdata,
    input  spi_seq_pkg::bit_cnt_t                bit_idx,
    output logic                                 tx_bit,
    input  logic                                 rx_we,
    input  logic                                 rx_bit
);

    localparam int nbits = 8 * `SPI_MEM_BYTES;
    localparam int bw    = $clog2(`SPI_MEM_BYTES);   // byte offset width
    localparam int aw    = $clog2(nbits);

    // index k holds stream bit k, msb of byte 0 goes out first
    logic [nbits-1:0] tx_mem;
    logic [nbits-1:0] rx_mem;
    logic [bw-1:0]    byte_off;
    logic             rx_sel;      // upper half of the index is the rx window
    logic [aw-1:0]    bit_off;

    assign byte_off = byte_idx[bw-1:0];
    assign rx_sel   = byte_idx[bw];
    assign bit_off  = bit_idx[aw-1:0];

    always_ff @(posedge SPI_CLK) begin
        if (byte_we) begin
            for (int i = 0; i < 8; i++)
                tx_mem[8 * byte_off + i] <= byte_wdata[7 - i];
        end
    end

    always_ff @(posedge SPI_CLK) begin
        for (int i = 0; i < 8; i++)
            byte_rdata[7 - i] <= rx_sel ? rx_mem[8 * byte_off + i] : tx_mem[8 * byte_off + i];
    end

    always_ff @(posedge SPI_CLK) begin
        if (rx_we)
            rx_mem[bit_off] <= rx_bit;  // one sdo sample per enabled cycle
    end

    assign tx_bit = tx_mem[bit_off];

endmodule

//--- hdl/spi_sequencer.sv
/*
 * frame sequencer: bit and repeat counters, done pulse,
 * sen/sdi on falling edges, gated sclk, sld strobe, sdo capture
 */
`timescale 1ns/10ps

module spi_sequencer (
    input  logic                   SPI_CLK,
    input  logic                   RST,
    spi_ctrl_if.seq                ctrl,
    output spi_seq_pkg::bit_cnt_t  bit_idx,
    input  logic                   tx_bit,
    output logic                   rx_we,
    output logic                   rx_bit,
    output logic                   sclk,
    output logic                   sdi,
    output logic                   sen,
    output logic                   sld,
    input  logic                   sdo
);
    import spi_seq_pkg::*;

    bit_cnt_t    cnt;          // 0 idle, 1..bit_out frame, then gap
    bit_cnt_t    stop_bit;
    byte_t       rep_cnt;      // current repetition, from 1
    logic        en;           // internal enable, rising edge domain
    logic        seq_rst;
    logic        at_stop;
    logic        more;
    logic        rep_start;
    logic        rep_start_dly;
    logic [1:0]  ld_sync;

    assign seq_rst  = RST || ctrl.soft_rst;
    assign stop_bit = ctrl.bit_out + ctrl.wait_len;
    assign at_stop  = (cnt != '0) && (cnt == stop_bit);

    // endless when repeat_len is 0
    assign more      = (ctrl.repeat_len == '0) || (rep_cnt < ctrl.repeat_len);
    assign rep_start = at_stop && more;
    assign ctrl.done = at_stop && !more;

    always_ff @(posedge SPI_CLK) begin
        if (seq_rst)
            rep_start_dly <= 1'b0;
        else
            rep_start_dly <= rep_start;  // one idle cycle between frames
    end

    always_ff @(posedge SPI_CLK) begin
        if (seq_rst)
            cnt <= '0;
        else if (ctrl.start)
            cnt <= 16'd1;
        else if (at_stop)
            cnt <= '0;
        else if (rep_start_dly)
            cnt <= 16'd1;
        else if (cnt != '0)
            cnt <= cnt + 16'd1;
    end

    always_ff @(posedge SPI_CLK) begin
        if (seq_rst)
            en <= 1'b0;
        else if (ctrl.start || rep_start_dly)
            en <= 1'b1;
        else if (cnt == ctrl.bit_out)
            en <= 1'b0;  // last bit shifted
    end

    always_ff @(posedge SPI_CLK) begin
        if (seq_rst || ctrl.start)
            rep_cnt <= 8'd1;
        else if (at_stop)
            rep_cnt <= rep_cnt + 8'd1;
    end

    // load strobe after the enable falls
    always_ff @(posedge SPI_CLK) begin
        if (seq_rst) begin
            ld_sync <= '0;
            sld     <= 1'b0;
        end else begin
            ld_sync <= {ld_sync[0], en};
            sld     <= ld_sync[1] && !ld_sync[0];
        end
    end

    // counter is one ahead of the bit being shifted
    assign bit_idx = cnt - 16'd1;
    assign rx_we   = en;
    assign rx_bit  = sdo;

    // pins change half a cycle after the internal state
    always_ff @(negedge SPI_CLK) begin
        if (RST) begin
            sen <= 1'b0;
            sdi <= 1'b0;
        end else begin
            sen <= en;
            sdi <= tx_bit && en;
        end
    end

    // sen only moves while SPI_CLK is low, so no glitch
    assign sclk = SPI_CLK && sen;

endmodule

//--- hdl/spi_core.sv
/*
 * SPI sequencer top level
 * register block, bit memories and frame sequencer
 */
`timescale 1ns/10ps
`include "spi_seq_config.svh"

module spi_core (
    input  logic                        SPI_CLK,
    input  logic                        RST,
    input  logic [`SPI_ABUS_WIDTH-1:0]  bus_add,
    input  spi_seq_pkg::byte_t          bus_data_in,
    input  logic                        bus_wr,
    input  logic                        bus_rd,        // reads have fixed latency, no strobe needed
    output spi_seq_pkg::byte_t          bus_data_out,
    output logic                        sclk,
    output logic                        sdi,
    output logic                        sen,
    output logic                        sld,
    input  logic                        sdo
);
    import spi_seq_pkg::*;

    logic                                 mem_we;
    logic [$clog2(2*`SPI_MEM_BYTES)-1:0]  mem_idx;
    byte_t                                mem_wdata;
    byte_t                                mem_rdata;
    bit_cnt_t                             bit_idx;
    logic                                 tx_bit;
    logic                                 rx_we;
    logic                                 rx_bit;

    spi_ctrl_if ctrl_if ();

    spi_regs i_regs (
        .SPI_CLK      (SPI_CLK),
        .RST          (RST),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .bus_data_out (bus_data_out),
        .mem_we       (mem_we),
        .mem_idx      (mem_idx),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .ctrl         (ctrl_if.regs)
    );

    spi_shift_mem i_mem (
        .SPI_CLK    (SPI_CLK),
        .byte_we    (mem_we),
        .byte_idx   (mem_idx),
        .byte_wdata (mem_wdata),
        .byte_rdata (mem_rdata),
        .bit_idx    (bit_idx),
        .tx_bit     (tx_bit),
        .rx_we      (rx_we),
        .rx_bit     (rx_bit)
    );

    spi_sequencer i_seq (
        .SPI_CLK (SPI_CLK),
        .RST     (RST),
        .ctrl    (ctrl_if.seq),
        .bit_idx (bit_idx),
        .tx_bit  (tx_bit),
        .rx_we   (rx_we),
        .rx_bit  (rx_bit),
        .sclk    (sclk),
        .sdi     (sdi),
        .sen     (sen),
        .sld     (sld),
        .sdo     (sdo)
    );

endmodule

//--- sim/tb_clk_gen.sv
/*
 * testbench clock and reset
 * 20 ns period, reset held for 5 cycles
 */
`timescale 1ns/10ps

module tb_clk_gen (
    output logic SPI_CLK,
    output logic RST
);

    initial begin
        SPI_CLK = 1'b0;
        forever #10 SPI_CLK = ~SPI_CLK;
    end

    initial begin
        RST = 1'b1;
        repeat (5) @(posedge SPI_CLK);
        @(negedge SPI_CLK);
        RST = 1'b0;  // released on a falling edge
    end

endmodule

//--- sim/spi_core_props.sv
/*
 * concurrent assertions on the SPI pins of spi_core
 * gated clock, load strobe width, pin state in reset
 */
`timescale 1ns/10ps

module spi_core_props (
    input logic SPI_CLK,
    input logic RST,
    input logic sclk,
    input logic sen,
    input logic sld
);

    logic sen_at_rise;  // sen as the rising edge saw it

    always_ff @(posedge SPI_CLK)
        sen_at_rise <= sen;

    // sclk is a whole high phase inside a frame and stays low outside one
    sclk_whole_pulse: assert property (
        @(negedge SPI_CLK) disable iff (RST) sclk == sen_at_rise)
        else $error("sclk pulse cut short or sclk high outside a frame");

    sld_one_cycle: assert property (@(posedge SPI_CLK) disable iff (RST) sld |=> !sld)
        else $error("sld high for more than one cycle");

    // sen clears on the first falling edge, so look from the second reset cycle
    pins_low_in_reset: assert property (@(posedge SPI_CLK) RST && $past(RST) |-> !sen && !sld)
        else $error("sen or sld high during reset");

endmodule

bind spi_core spi_core_props i_props (
    .SPI_CLK (SPI_CLK),
    .RST     (RST),
    .sclk    (sclk),
    .sen     (sen),
    .sld     (sld)
);

//--- sim/spi_core_tb.sv
/*
 * testbench for spi_core: slave model, LFSR stimulus,
 * reference model, compare process, watchdog
 */
`timescale 1ns/10ps
`include "spi_seq_config.svh"

module spi_core_tb;
    import spi_seq_pkg::*;

    localparam int nbytes    = `SPI_MEM_BYTES;
    localparam int tx_base   = 8;
    localparam int rx_base   = 8 + nbytes;
    localparam int full_bits = 8 * nbytes;
    localparam int rep_bits  = 24;
    localparam int rep_wait  = 5;
    // frames of tests 3 to 6 plus polling, doubled, plus bus traffic
    localparam int watchdog_cycles =
        2 * (full_bits + 13 + 6 * (rep_bits + rep_wait + 2)) + 2000;

    logic                        SPI_CLK;
    logic                        RST;
    logic [`SPI_ABUS_WIDTH-1:0]  bus_add;
    byte_t                       bus_data_in;
    byte_t                       bus_data_out;
    logic                        bus_wr;
    logic                        bus_rd;
    logic                        sclk;
    logic                        sdi;
    logic                        sen;
    logic                        sld;
    logic                        sdo;

    byte_t       tx_img [nbytes];   // what the tx memory should hold
    byte_t       rx_img [nbytes];   // predicted rx memory
    logic [15:0] lfsr_state = 16'd40692;
    int          errors = 0;
    int          checks = 0;
    int          test_err = 0;
    int          sclk_edges = 0;
    int          sld_pulses = 0;
    int          sen_cycles = 0;
    int          got_q[$];
    int          exp_q[$];
    string       tag_q[$];

    tb_clk_gen i_clk_gen (.SPI_CLK(SPI_CLK), .RST(RST));

    spi_core i_dut (
        .SPI_CLK      (SPI_CLK),
        .RST          (RST),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .bus_rd       (bus_rd),
        .bus_data_out (bus_data_out),
        .sclk         (sclk),
        .sdi          (sdi),
        .sen          (sen),
        .sld          (sld),
        .sdo          (sdo)
    );

    // slave echoes the complement of what it receives
    assign sdo = ~sdi;

    always @(posedge sclk) sclk_edges++;
    always @(posedge sld) sld_pulses++;
    always @(posedge SPI_CLK) if (sen) sen_cycles++;  // sen is stable at rising edges

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_byte(output byte_t b);
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr_state[15]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // rx byte after a frame of nbits, stream bit k is bit 7-k%8 of byte k/8
    function automatic byte_t ref_rx_byte(input int idx, input int nbits);
        byte_t r;
        int    k;
        for (int b = 0; b < 8; b++) begin
            k = 8 * idx + 7 - b;
            r[b] = (k < nbits) ? ~tx_img[idx][b] : rx_img[idx][b];
        end
        return r;
    endfunction

    function automatic int reg_default(input int a);
        case (a)
            0:       return `SPI_VERSION;
            1:       return 1;                    // done flag
            3:       return full_bits & 'hff;
            4:       return (full_bits >> 8) & 'hff;
            7:       return 1;
            default: return 0;
        endcase
    endfunction

    task automatic expect_val(input int got, input int exp, input string tag);
        got_q.push_back(got);
        exp_q.push_back(exp);
        tag_q.push_back(tag);
    endtask

    // compare process, drains the queue of pending checks
    always @(negedge SPI_CLK) begin
        while (exp_q.size() > 0) begin
            assert (got_q[0] == exp_q[0]) else begin
                $display("Mismatch at %0d ns: %s got %0h expected %0h",
                         $time, tag_q[0], got_q[0], exp_q[0]);
                errors++;
            end
            checks++;
            void'(got_q.pop_front());
            void'(exp_q.pop_front());
            void'(tag_q.pop_front());
        end
    end

    // bus tasks start and end on a falling edge
    task automatic bus_write(input int add, input int data);
        bus_add     = `SPI_ABUS_WIDTH'(add);
        bus_data_in = byte_t'(data);
        bus_wr      = 1'b1;
        @(negedge SPI_CLK);
        bus_wr = 1'b0;
    endtask

    task automatic bus_read(input int add, output byte_t data);
        bus_add = `SPI_ABUS_WIDTH'(add);
        bus_rd  = 1'b1;
        @(negedge SPI_CLK);
        data   = bus_data_out;  // one cycle read latency
        bus_rd = 1'b0;
    endtask

    task automatic set_frame(input int nbits, input int gap, input int reps);
        bus_write(3, nbits & 'hff);
        bus_write(4, nbits >> 8);
        bus_write(5, gap & 'hff);
        bus_write(6, gap >> 8);
        bus_write(7, reps);
    endtask

    task automatic run_frames(input int nbits, input int gap, input int reps, input string name);
        byte_t d;
        int    limit;
        bit    seen;
        limit = reps * (nbits + gap + 2) + 20;
        seen = 1'b0;
        sclk_edges = 0;
        sld_pulses = 0;
        sen_cycles = 0;
        bus_write(1, 0);
        for (int i = 0; i < limit && !seen; i++) begin
            bus_read(1, d);
            seen = d[0];
        end
        assert (seen) else begin
            $display("Timeout: done flag stayed low after start in %s", name);
            errors++;
        end
        checks++;
        repeat (4) @(negedge SPI_CLK);  // last sld follows done
        expect_val(sclk_edges, nbits * reps, {name, " sclk edges"});
        expect_val(sen_cycles, nbits * reps, {name, " sen cycles"});
        expect_val(sld_pulses, reps, {name, " sld pulses"});
    endtask

    task automatic check_rx(input int nbits, input string name);
        byte_t d;
        byte_t exp;
        for (int i = 0; i < nbytes; i++) begin
            bus_read(rx_base + i, d);
            exp = ref_rx_byte(i, nbits);
            expect_val(d, exp, $sformatf("%s rx byte %0d", name, i));
            rx_img[i] = exp;
        end
    endtask

    task automatic finish_test(input string name);
        while (exp_q.size() != 0)
            @(negedge SPI_CLK);
        $display("%s: %0d errors", name, errors - test_err);
        test_err = errors;
    endtask

    initial begin
        byte_t d;
        int    limit;
        bus_add     = '0;
        bus_data_in = '0;
        bus_wr      = 1'b0;
        bus_rd      = 1'b0;
        @(negedge RST);
        @(negedge SPI_CLK);
        sclk_edges = 0;
        sld_pulses = 0;
        sen_cycles = 0;

        for (int a = 0; a < 8; a++) begin
            bus_read(a, d);
            expect_val(d, reg_default(a), $sformatf("reset reg %0d", a));
        end
        expect_val(sen_cycles + sclk_edges + sld_pulses, 0, "pin activity after reset");
        finish_test("test 1 reset values");

        for (int i = 0; i < nbytes; i++) begin
            draw_byte(tx_img[i]);
            bus_write(tx_base + i, tx_img[i]);
        end
        for (int i = 0; i < nbytes; i++) begin
            bus_read(tx_base + i, d);
            expect_val(d, tx_img[i], $sformatf("tx byte %0d", i));
        end
        finish_test("test 2 tx readback");

        set_frame(full_bits, 0, 1);
        run_frames(full_bits, 0, 1, "full frame");
        check_rx(full_bits, "full frame");
        finish_test("test 3 full frame");

        // fresh pattern in every byte, frame ends inside byte 1
        for (int i = 0; i < nbytes; i++) begin
            draw_byte(tx_img[i]);
            bus_write(tx_base + i, tx_img[i]);
        end
        set_frame(13, 0, 1);
        run_frames(13, 0, 1, "partial frame");
        check_rx(13, "partial frame");
        finish_test("test 4 partial frame");

        set_frame(rep_bits, rep_wait, 3);
        run_frames(rep_bits, rep_wait, 3, "repeat");
        bus_read(1, d);
        expect_val(d, 1, "done after repeats");
        check_rx(rep_bits, "repeat");
        finish_test("test 5 repeats");

        set_frame(rep_bits, rep_wait, 0);
        sld_pulses = 0;
        bus_write(1, 0);
        limit = 3 * (rep_bits + rep_wait + 2) + 20;
        for (int i = 0; i < limit && sld_pulses < 2; i++)
            @(negedge SPI_CLK);
        assert (sld_pulses >= 2) else begin
            $display("Timeout: endless run gave fewer than two sld pulses");
            errors++;
        end
        checks++;
        bus_write(0, 0);
        sen_cycles = 0;
        repeat (10) @(negedge SPI_CLK);
        expect_val(sen_cycles, 0, "sen after soft reset");
        for (int a = 1; a < 8; a++) begin
            bus_read(a, d);
            expect_val(d, reg_default(a), $sformatf("soft reset reg %0d", a));
        end
        finish_test("test 6 endless and soft reset");

        $display("totals: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge SPI_CLK);
        $display("Watchdog: run did not finish within %0d cycles", watchdog_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- spi_seq.f
+incdir+hdl
hdl/spi_seq_pkg.sv
hdl/spi_ctrl_if.sv
hdl/spi_regs.sv
hdl/spi_shift_mem.sv
hdl/spi_sequencer.sv
hdl/spi_core.sv
sim/tb_clk_gen.sv
sim/spi_core_props.sv
sim/spi_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the spi_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f spi_seq.f --top-module spi_core_tb -Mdir obj_dir -o sim_spi_core
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/sim_spi_core > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "result: pass"
    exit 0
else
    echo "result: fail"
    exit 1
fi
